/* lsu_settings.svh */
// ----------------------------------------------------------
// Sizing macros for the load/store execute unit
// Included by the RTL and the testbench wherever tag width
// or memory geometry is needed
// ----------------------------------------------------------

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Sequence tag carried from dispatch to writeback
`define LSU_TAG_BITS 4

// Data memory geometry, in 32-bit words
`define LSU_MEM_WORDS 64

// Word index width, log2 of the word count
`define LSU_IDX_BITS 6

`endif

/* design/lsu_pkg.sv */
// ----------------------------------------------------------
// Shared types for the load/store execute unit
// Micro-op and memory-op encodings, response word view
// ----------------------------------------------------------

package lsu_pkg;

  // ----------------------------------------------------------
  // Micro-op encoding from dispatch
  // ----------------------------------------------------------

  typedef enum logic [2:0] {
    OP_LB,   // Signed byte load
    OP_LH,   // Signed halfword load
    OP_LW,
    OP_LBU,  // Unsigned byte load
    OP_LHU,  // Unsigned halfword load
    OP_SB,
    OP_SH,
    OP_SW
  } mem_uop_e;

  // Memory request kind
  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

  // ----------------------------------------------------------
  // Response word, decoded as bytes or as halves
  // ----------------------------------------------------------

  typedef union packed {
    logic [31:0]      word;
    logic [3:0][7:0]  byte_lane;  // Lane 0 is the low byte
    logic [1:0][15:0] half_lane;  // Lane 1 is the upper half
  } load_word_u;

endpackage

/* design/lsu_ctrl.sv */
// ----------------------------------------------------------
// Pipeline control for the load/store execute unit
// Owns the stage 1 and stage 2 registers and every
// valid/ready term between dispatch, memory and writeback
// ----------------------------------------------------------

`include "lsu_settings.svh"

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,

  // Dispatch side
  input  logic                      d_val,
  output logic                      d_rdy,
  input  mem_uop_e                  d_uop,
  input  logic [31:0]               d_op1,
  input  logic [31:0]               d_op2,
  input  logic [31:0]               d_sdata,
  input  logic [`LSU_TAG_BITS-1:0]  d_tag,

  // Request fields from the builder
  input  mem_op_e                   req_op,
  input  logic [`LSU_IDX_BITS-1:0]  req_idx,
  input  logic [1:0]                s1_offset,

  // Memory handshakes
  output logic                      req_val,
  input  logic                      req_rdy,
  input  logic                      resp_val,
  output logic                      resp_rdy,

  // Stage 1 entry toward the builder
  output mem_uop_e                  s1_uop,
  output logic [31:0]               s1_op1,
  output logic [31:0]               s1_op2,
  output logic [31:0]               s1_sdata,

  // Stage 2 entry toward the aligner
  output mem_uop_e                  s2_uop,
  output logic [1:0]                s2_offset,

  // Writeback side
  output logic                      w_val,
  input  logic                      w_rdy,
  output logic [`LSU_TAG_BITS-1:0]  w_tag
);

  logic                     s1_val;
  logic [`LSU_TAG_BITS-1:0] s1_tag;
  logic                     s2_val;
  logic [`LSU_TAG_BITS-1:0] s2_tag;
  logic                     s2_rdy;
  logic                     d_xfer;
  logic                     req_xfer;  // Also the stage 2 load
  logic                     w_xfer;

  // ----------------------------------------------------------
  // Handshake terms
  // ----------------------------------------------------------

  assign s2_rdy   = (w_rdy & resp_val) | !s2_val;
  assign req_val  = s1_val & s2_rdy;
  assign d_rdy    = (s2_rdy & req_rdy) | !s1_val;
  assign resp_rdy = s2_val & w_rdy;
  assign w_val    = s2_val & resp_val;

  assign d_xfer   = d_val & d_rdy;
  assign req_xfer = req_val & req_rdy;
  assign w_xfer   = w_val & w_rdy;

  // ----------------------------------------------------------
  // Stage 1: operands waiting for the memory
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val <= 1'b0;
    end else if (d_xfer) begin
      s1_val <= 1'b1;           // Refill wins over drain
    end else if (req_xfer) begin
      s1_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (d_xfer) begin
      s1_uop   <= d_uop;
      s1_op1   <= d_op1;
      s1_op2   <= d_op2;
      s1_sdata <= d_sdata;
      s1_tag   <= d_tag;
    end
  end

  // ----------------------------------------------------------
  // Stage 2: waiting for response and writeback
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_val <= 1'b0;
    end else if (req_xfer) begin
      s2_val <= 1'b1;
    end else if (w_xfer) begin
      s2_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_xfer) begin
      s2_uop    <= s1_uop;
      s2_offset <= s1_offset;   // Low address bits for the aligner
      s2_tag    <= s1_tag;
    end
  end

  assign w_tag = s2_tag;

  // The memory writes at acceptance, so no read-after-write hazard
  // exists; req_op and req_idx feed only the bound stability checks

endmodule

/* design/lsu_req_build.sv */
// ----------------------------------------------------------
// Memory request builder, purely combinational
// Forms the address from stage 1 operands, then the word
// index, lane mask and lane-shifted store data
// ----------------------------------------------------------

`include "lsu_settings.svh"

module lsu_req_build
  import lsu_pkg::*;
(
  input  mem_uop_e                  s1_uop,
  input  logic [31:0]               s1_op1,
  input  logic [31:0]               s1_op2,
  input  logic [31:0]               s1_sdata,
  output mem_op_e                   req_op,
  output logic [`LSU_IDX_BITS-1:0]  req_idx,
  output logic [3:0]                req_mask,
  output logic [31:0]               req_data,
  output logic [1:0]                s1_offset
);

  logic [31:0] addr;
  logic [3:0]  base_mask;

  assign addr      = s1_op1 + s1_op2;
  assign req_idx   = addr[`LSU_IDX_BITS+1:2];  // Upper bits wrap the memory
  assign s1_offset = addr[1:0];

  // Access size picks the unshifted lanes
  always_comb begin
    case (s1_uop)
      OP_LB, OP_LBU, OP_SB: base_mask = 4'b0001;
      OP_LH, OP_LHU, OP_SH: base_mask = 4'b0011;
      default:              base_mask = 4'b1111;
    endcase
  end

  // Lanes pushed past lane 3 fall off
  assign req_mask = base_mask << s1_offset;
  assign req_data = s1_sdata << {s1_offset, 3'b000};

  always_comb begin
    case (s1_uop)
      OP_SB, OP_SH, OP_SW: req_op = MEM_WRITE;
      default:             req_op = MEM_READ;
    endcase
  end

endmodule

/* design/lsu_load_align.sv */
// ----------------------------------------------------------
// Load aligner, purely combinational
// Selects the addressed byte or halfword of the response
// word, extends it, and flags loads for register write
// ----------------------------------------------------------

module lsu_load_align
  import lsu_pkg::*;
(
  input  mem_uop_e    s2_uop,
  input  logic [1:0]  s2_offset,
  input  load_word_u  resp_data,
  output logic [31:0] w_data,
  output logic        w_wen
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  assign sel_byte = resp_data.byte_lane[s2_offset];
  assign sel_half = resp_data.half_lane[s2_offset[1]];  // Aligned halves only

  always_comb begin
    case (s2_uop)
      OP_LB:   w_data = {{24{sel_byte[7]}}, sel_byte};
      OP_LH:   w_data = {{16{sel_half[15]}}, sel_half};
      OP_LBU:  w_data = {24'd0, sel_byte};
      OP_LHU:  w_data = {16'd0, sel_half};
      default: w_data = resp_data.word;  // LW, and stores don't care
    endcase
  end

  // Stores come back with write-enable low
  always_comb begin
    case (s2_uop)
      OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: w_wen = 1'b1;
      default:                             w_wen = 1'b0;
    endcase
  end

endmodule

/* design/lsu_data_mem.sv */
// ----------------------------------------------------------
// Local data memory with byte-lane writes
// Accepts one request per cycle and answers on the next
// edge from a one-entry response register
// ----------------------------------------------------------

`include "lsu_settings.svh"

module lsu_data_mem
  import lsu_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,

  // Request side
  input  logic                      req_val,
  output logic                      req_rdy,
  input  mem_op_e                   req_op,
  input  logic [`LSU_IDX_BITS-1:0]  req_idx,
  input  logic [3:0]                req_mask,
  input  logic [31:0]               req_data,

  // Response side
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output logic [31:0]               resp_data
);

  logic [31:0] words [`LSU_MEM_WORDS];
  logic        req_xfer;

  // Stall while an untaken response is held
  assign req_rdy  = !resp_val | resp_rdy;
  assign req_xfer = req_val & req_rdy;

  // ----------------------------------------------------------
  // Storage and response word
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_xfer) begin
      resp_data <= words[req_idx];  // Old word on a write
      if (req_op == MEM_WRITE) begin
        for (int i = 0; i < 4; i++) begin
          if (req_mask[i]) begin
            words[req_idx][i*8 +: 8] <= req_data[i*8 +: 8];
          end
        end
      end
    end
  end

  // Response occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_val <= 1'b0;
    end else if (req_xfer) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

endmodule

/* design/lsu_top.sv */
// ----------------------------------------------------------
// Load/store execute unit top level
// Pipeline control with request builder, load aligner
// and local data memory; dispatch in, writeback out
// ----------------------------------------------------------

`include "lsu_settings.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,

  input  logic                      d_val,
  output logic                      d_rdy,
  input  mem_uop_e                  d_uop,
  input  logic [31:0]               d_op1,
  input  logic [31:0]               d_op2,
  input  logic [31:0]               d_sdata,
  input  logic [`LSU_TAG_BITS-1:0]  d_tag,

  output logic                      w_val,
  input  logic                      w_rdy,
  output logic                      w_wen,
  output logic [31:0]               w_data,
  output logic [`LSU_TAG_BITS-1:0]  w_tag
);

  // Memory link
  logic                     req_val;
  logic                     req_rdy;
  mem_op_e                  req_op;
  logic [`LSU_IDX_BITS-1:0] req_idx;
  logic [3:0]               req_mask;
  logic [31:0]              req_data;
  logic                     resp_val;
  logic                     resp_rdy;
  load_word_u               resp_data;

  // Stage entries
  mem_uop_e                 s1_uop;
  logic [31:0]              s1_op1;
  logic [31:0]              s1_op2;
  logic [31:0]              s1_sdata;
  logic [1:0]               s1_offset;
  mem_uop_e                 s2_uop;
  logic [1:0]               s2_offset;

  lsu_ctrl ctrl0 (
    .clk       (clk),
    .rst       (rst),
    .d_val     (d_val),
    .d_rdy     (d_rdy),
    .d_uop     (d_uop),
    .d_op1     (d_op1),
    .d_op2     (d_op2),
    .d_sdata   (d_sdata),
    .d_tag     (d_tag),
    .req_op    (req_op),
    .req_idx   (req_idx),
    .s1_offset (s1_offset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .s1_uop    (s1_uop),
    .s1_op1    (s1_op1),
    .s1_op2    (s1_op2),
    .s1_sdata  (s1_sdata),
    .s2_uop    (s2_uop),
    .s2_offset (s2_offset),
    .w_val     (w_val),
    .w_rdy     (w_rdy),
    .w_tag     (w_tag)
  );

  lsu_req_build build0 (
    .s1_uop    (s1_uop),
    .s1_op1    (s1_op1),
    .s1_op2    (s1_op2),
    .s1_sdata  (s1_sdata),
    .req_op    (req_op),
    .req_idx   (req_idx),
    .req_mask  (req_mask),
    .req_data  (req_data),
    .s1_offset (s1_offset)
  );

  lsu_data_mem mem0 (
    .clk       (clk),
    .rst       (rst),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .req_op    (req_op),
    .req_idx   (req_idx),
    .req_mask  (req_mask),
    .req_data  (req_data),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .resp_data (resp_data)
  );

  lsu_load_align align0 (
    .s2_uop    (s2_uop),
    .s2_offset (s2_offset),
    .resp_data (resp_data),
    .w_data    (w_data),
    .w_wen     (w_wen)
  );

endmodule

/* bench/lsu_props.sv */
// ----------------------------------------------------------
// Handshake and reset properties for the pipeline control
// Bound into every lsu_ctrl instance by the testbench
// ----------------------------------------------------------

`include "lsu_settings.svh"

module lsu_props
  import lsu_pkg::*;
(
  input logic                      clk,
  input logic                      rst,
  input logic                      d_rdy,
  input logic                      s1_val,
  input logic                      req_val,
  input logic                      req_rdy,
  input mem_op_e                   req_op,
  input logic [`LSU_IDX_BITS-1:0]  req_idx,
  input logic                      w_val,
  input logic                      w_rdy,
  input logic [`LSU_TAG_BITS-1:0]  w_tag
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // Read by the testbench verdict

  // Writeback entry holds while stalled
  w_hold: assert property (@(posedge clk) disable iff (rst)
    (w_val && !w_rdy) |=> (w_val && $stable(w_tag)))
    else begin
      fail_count++;
      $error("w_val or w_tag changed while w_rdy was low");
    end

  // Stage 1 request holds until the memory takes it
  req_hold: assert property (@(posedge clk) disable iff (rst)
    (s1_val && !(req_val && req_rdy)) |=>
      (s1_val && $stable(req_op) && $stable(req_idx)))
    else begin
      fail_count++;
      $error("stage 1 request changed before the memory accepted it");
    end

  // First cycle out of reset
  reset_exit: assert property (@(posedge clk) $fell(rst) |-> (!w_val && d_rdy))
    else begin
      fail_count++;
      $error("w_val high or d_rdy low in the first cycle after reset");
    end

endmodule

/* bench/lsu_tb.sv */
// ----------------------------------------------------------
// Directed testbench for the load/store execute unit
// Dispatches micro-ops, collects writebacks in order and
// checks them against a shadow memory model
// ----------------------------------------------------------

`include "lsu_settings.svh"

module lsu_tb
  import lsu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CYCLE_LIMIT = 2000;
  localparam logic [31:0] SEED = 32'h8d57_cf7c;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     d_val;
  logic                     d_rdy;
  mem_uop_e                 d_uop;
  logic [31:0]              d_op1;
  logic [31:0]              d_op2;
  logic [31:0]              d_sdata;
  logic [`LSU_TAG_BITS-1:0] d_tag;
  logic                     w_val;
  logic                     w_rdy;
  logic                     w_wen;
  logic [31:0]              w_data;
  logic [`LSU_TAG_BITS-1:0] w_tag;

  // Reference model state
  logic [31:0]              shadow [`LSU_MEM_WORDS];
  logic [31:0]              exp_data [$];
  logic [`LSU_TAG_BITS-1:0] exp_tag [$];
  logic                     exp_wen [$];
  logic [31:0]              got_data [$];
  logic [`LSU_TAG_BITS-1:0] got_tag [$];
  logic                     got_wen [$];
  logic [`LSU_TAG_BITS-1:0] next_tag = '0;
  logic [31:0]              rng = SEED;       // Stimulus values
  logic [31:0]              stall_rng = SEED; // w_rdy pattern
  logic                     rand_rdy = 1'b0;
  int                       errors = 0;
  int                       test_errors;
  int                       tests_run = 0;
  int                       tests_ok = 0;
  int                       stalls;
  string                    test_name;

  always #2 clk = ~clk;

  lsu_top dut0 (.*);

  bind lsu_ctrl lsu_props props0 (.*);

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected load result from the shadow word
  function automatic logic [31:0] load_expect(mem_uop_e uop, logic [31:0] word,
                                              logic [1:0] off);
    load_word_u v;
    v.word = word;
    case (uop)
      OP_LB:   return {{24{v.byte_lane[off][7]}}, v.byte_lane[off]};
      OP_LBU:  return {24'd0, v.byte_lane[off]};
      OP_LH:   return {{16{v.half_lane[off[1]][15]}}, v.half_lane[off[1]]};
      OP_LHU:  return {16'd0, v.half_lane[off[1]]};
      default: return v.word;
    endcase
  endfunction

  // Bytes land from the offset upward, anything past lane 3 is lost
  function automatic void shadow_store(mem_uop_e uop, logic [31:0] addr, logic [31:0] sdata);
    int nbytes;
    int lane;
    nbytes = (uop == OP_SB) ? 1 : (uop == OP_SH) ? 2 : 4;
    for (int i = 0; i < nbytes; i++) begin
      lane = addr[1:0] + i;
      if (lane < 4) begin
        shadow[addr[`LSU_IDX_BITS+1:2]][lane*8 +: 8] = sdata[i*8 +: 8];
      end
    end
  endfunction

  // ----------------------------------------------------------
  // Writeback collector and random back-pressure
  // ----------------------------------------------------------

  always @(negedge clk) begin
    #1;  // Outputs settled after the falling-edge drive
    if (w_val && w_rdy) begin
      got_data.push_back(w_data);
      got_tag.push_back(w_tag);
      got_wen.push_back(w_wen);
    end
  end

  always @(negedge clk) begin
    if (rand_rdy) begin
      stall_rng = xorshift(stall_rng);
      w_rdy = stall_rng[7];
    end
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------

  task automatic check_data(logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED %s data: expected %h, actual %h", test_name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_tag(logic [`LSU_TAG_BITS-1:0] exp, logic [`LSU_TAG_BITS-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s tag: expected %h, actual %h", test_name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_wen(logic exp, logic act);
    if (act !== exp) begin
      $display("FAILED %s wen: expected %b, actual %b", test_name, exp, act);
      test_errors++;
    end
  endtask

  // ----------------------------------------------------------
  // Dispatch, drain and test bookkeeping
  // ----------------------------------------------------------

  task automatic issue(mem_uop_e uop, logic [31:0] base, logic [31:0] off, logic [31:0] sdata);
    logic [31:0] addr;
    logic        is_store;
    addr = base + off;
    is_store = (uop == OP_SB) || (uop == OP_SH) || (uop == OP_SW);
    @(negedge clk);
    d_val = 1'b1;
    d_uop = uop;
    d_op1 = base;
    d_op2 = off;
    d_sdata = sdata;
    d_tag = next_tag;
    #1;
    while (!d_rdy) begin
      stalls++;
      @(negedge clk);
      #1;
    end
    exp_tag.push_back(next_tag);   // Transfer happens on the coming edge
    exp_wen.push_back(!is_store);
    if (is_store) begin
      exp_data.push_back(32'h0);   // Store data is not compared
      shadow_store(uop, addr, sdata);
    end else begin
      exp_data.push_back(load_expect(uop, shadow[addr[`LSU_IDX_BITS+1:2]], addr[1:0]));
    end
    next_tag++;
  endtask

  task automatic drain();
    logic        ew;
    logic [31:0] gd;
    @(negedge clk);
    d_val = 1'b0;
    while (got_tag.size() < exp_tag.size()) begin
      @(negedge clk);
    end
    while (exp_tag.size() > 0) begin
      ew = exp_wen.pop_front();
      gd = got_data.pop_front();
      check_wen(ew, got_wen.pop_front());
      check_tag(exp_tag.pop_front(), got_tag.pop_front());
      if (ew) begin
        check_data(exp_data.pop_front(), gd);
      end else begin
        void'(exp_data.pop_front());
      end
    end
    if (got_tag.size() != 0) begin
      $display("%s: writeback arrived with no matching dispatch", test_name);
      test_errors++;
      got_tag.delete();
      got_data.delete();
      got_wen.delete();
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      tests_ok++;
      $display("%-18s ok", test_name);
    end else begin
      $display("%-18s %0d errors", test_name, test_errors);
    end
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------

  task automatic fill_memory();
    start_test("memory_fill");
    for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
      issue(OP_SW, i * 4, 0, {i[7:0] ^ 8'h9c, i[7:0], ~i[7:0], i[7:0] ^ 8'h35});
    end
    drain();
    finish_test();
  endtask

  task automatic word_round_trip();
    start_test("word_round_trip");
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      issue(OP_SW, 32'h40, i * 8, rng);
    end
    for (int i = 0; i < 8; i++) begin
      issue(OP_LW, 32'h40, i * 8, 32'h0);
    end
    drain();
    finish_test();
  endtask

  task automatic partial_merge();
    start_test("partial_merge");
    for (int k = 0; k < 4; k++) begin
      issue(OP_SB, 32'h14, k, 32'hffff_ff00 | (32'ha0 + k));  // Upper bits must drop
    end
    issue(OP_LW, 32'h14, 0, 32'h0);
    issue(OP_SH, 32'h28, 0, 32'hdead_1234);
    issue(OP_LW, 32'h28, 0, 32'h0);
    issue(OP_SH, 32'h28, 2, 32'hbeef_8765);
    issue(OP_LW, 32'h28, 0, 32'h0);
    drain();
    finish_test();
  endtask

  task automatic extension_rules();
    logic [31:0] base;
    start_test("extension_rules");
    issue(OP_SW, 32'h30, 0, 32'h80ff_7f01);  // Top bits set and clear per lane
    issue(OP_SW, 32'h34, 0, 32'h7ffe_8001);
    for (int w = 0; w < 2; w++) begin
      base = 32'h30 + w * 4;
      for (int k = 0; k < 4; k++) begin
        issue(OP_LB, base, k, 32'h0);
        issue(OP_LBU, base, k, 32'h0);
        if (k % 2 == 0) begin
          issue(OP_LH, base, k, 32'h0);
          issue(OP_LHU, base, k, 32'h0);
        end
      end
    end
    drain();
    finish_test();
  endtask

  task automatic ordering_backpressure();
    mem_uop_e    uop;
    logic [31:0] off;
    start_test("ordering_stall");
    rand_rdy = 1'b1;
    for (int i = 0; i < 30; i++) begin
      rng = xorshift(rng);
      uop = mem_uop_e'(rng[2:0]);
      case (uop)
        OP_LW, OP_SW:        off = 32'h0;
        OP_LH, OP_LHU, OP_SH: off = {30'd0, rng[12], 1'b0};
        default:             off = {30'd0, rng[13:12]};
      endcase
      issue(uop, 32'h80 + rng[10:8] * 4, off, xorshift(rng));
    end
    drain();
    @(negedge clk);
    rand_rdy = 1'b0;
    w_rdy = 1'b1;
    finish_test();
  endtask

  task automatic latency_stream();
    start_test("latency_stream");
    issue(OP_LW, 32'h40, 0, 32'h0);
    @(negedge clk);
    d_val = 1'b0;
    #1;
    if (w_val) begin
      $display("%s: w_val rose one edge after dispatch", test_name);
      test_errors++;
    end
    @(negedge clk);
    #1;
    if (!w_val) begin
      $display("%s: w_val not high two edges after dispatch", test_name);
      test_errors++;
    end
    drain();
    stalls = 0;
    for (int i = 0; i < 8; i++) begin
      issue((i % 2 == 0) ? OP_LW : OP_LHU, 32'h60, i * 2, 32'h0);
    end
    if (stalls != 0) begin
      $display("%s: d_rdy dropped during the load burst", test_name);
      test_errors++;
    end
    drain();
    finish_test();
  endtask

  // ----------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------

  initial begin
    rst = 1'b1;
    d_val = 1'b0;
    d_uop = OP_LW;
    d_op1 = 32'h0;
    d_op2 = 32'h0;
    d_sdata = 32'h0;
    d_tag = '0;
    w_rdy = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fill_memory();
    word_round_trip();
    partial_merge();
    extension_rules();
    ordering_backpressure();
    latency_stream();
    if (dut0.ctrl0.props0.fail_count != 0) begin
      $display("%0d assertion failures in the handshake properties",
               dut0.ctrl0.props0.fail_count);
      errors += dut0.ctrl0.props0.fail_count;
    end
    $display("%0d tests run, %0d ok, %0d errors", tests_run, tests_ok, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* lsu_top.f */
+incdir+.
design/lsu_pkg.sv
design/lsu_ctrl.sv
design/lsu_req_build.sv
design/lsu_load_align.sv
design/lsu_data_mem.sv
design/lsu_top.sv
bench/lsu_props.sv
bench/lsu_tb.sv
